// File: files.f
design/arm_ctrl_pkg.sv
design/ctrl_step_if.sv
design/dataproc_steps.sv
design/transfer_steps.sv
design/step_sequencer.sv
design/arm_control_unit.sv
verif/arm_control_unit_assertions.sv
verif/tb_arm_control_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f files.f \
  --top-module tb_arm_control_unit

./obj_dir/Vtb_arm_control_unit 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "Testbench reported a failure, see sim.log"
  exit 1
fi

echo "Run finished, log in sim.log"
exit 0

// File: verif/tb_arm_control_unit.sv
`timescale 1ns/1ps

module tb_arm_control_unit;
  import arm_ctrl_pkg::*;

  localparam int MAX_CYCLES = 10;

  // Reference model states
  localparam int M_RESET = 0;
  localparam int M_FILL  = 1;
  localparam int M_PRIME = 2;
  localparam int M_RUN   = 3;

  // Stimulus modes
  localparam int MODE_FIXED = 0;
  localparam int MODE_FLUSH = 1;
  localparam int MODE_SKIP  = 2;
  localparam int MODE_MIXED = 3;

  logic        clk;
  logic        reset;
  logic        flush_req;
  instr_kind_t instr_kind;
  logic        condition_pass;
  word_t       ir;

  addr_src_t   addr_src;
  b_src_t      b_src;
  imm12_t      b_imm;
  shift_t      shift_type;
  shamt_t      shift_amount;
  alu_op_t     alu_op;
  alu_wb_t     alu_wb;
  logic        set_flags;
  logic        use_rrx;
  logic        latch_op_b;
  logic        disable_op_b;
  logic        use_op_b_latch;
  logic        mem_read;
  logic        mem_write;
  logic        byte_xfer;
  logic        latch_ir;
  logic        incr_wb;
  logic        pipeline_advance;

  // Expected control word from the reference model
  addr_src_t   e_addr_src;
  b_src_t      e_b_src;
  imm12_t      e_b_imm;
  shift_t      e_shift_type;
  shamt_t      e_shift_amount;
  alu_op_t     e_alu_op;
  alu_wb_t     e_alu_wb;
  logic        e_set_flags;
  logic        e_use_rrx;
  logic        e_latch_op_b;
  logic        e_disable_op_b;
  logic        e_use_op_b_latch;
  logic        e_mem_read;
  logic        e_mem_write;
  logic        e_byte_xfer;
  logic        e_latch_ir;
  logic        e_incr_wb;
  logic        e_adv;

  integer      seed;
  int          m_state;
  int          m_step;
  int          checks;
  int          errors;
  int          hung;

  arm_control_unit arm_control_unit_inst (.*);

  always #2 clk = ~clk;

  // ====================================================================
  // Reference model
  // ====================================================================

  task automatic set_fetch(input addr_src_t src);
    e_mem_read = 1'b1;
    e_latch_ir = 1'b1;
    e_incr_wb  = 1'b1;
    e_addr_src = src;
  endtask

  // Rm with an immediate shift where ROR #0 means RRX
  task automatic reg_offset();
    e_b_src        = B_SRC_RM;
    e_shift_type   = ir[6:5];
    e_shift_amount = ir[11:7];
    e_use_rrx      = (ir[6:5] == 2'b11) && (ir[11:7] == 5'd0);
  endtask

  task automatic predict();
    logic    kept;
    logic    wb;
    alu_op_t op;
    e_addr_src       = ADDR_SRC_PC;
    e_b_src          = B_SRC_IMM;
    e_b_imm          = '0;
    e_shift_type     = SHIFT_LSL;
    e_shift_amount   = '0;
    e_alu_op         = '0;
    e_alu_wb         = ALU_WB_NONE;
    e_set_flags      = 1'b0;
    e_use_rrx        = 1'b0;
    e_latch_op_b     = 1'b0;
    e_disable_op_b   = 1'b0;
    e_use_op_b_latch = 1'b0;
    e_mem_read       = 1'b0;
    e_mem_write      = 1'b0;
    e_byte_xfer      = 1'b0;
    e_latch_ir       = 1'b0;
    e_incr_wb        = 1'b0;
    e_adv            = 1'b0;
    kept = (instr_kind == KIND_DP_IMM) || (instr_kind == KIND_DP_REG_IMM) ||
           (instr_kind == KIND_LOAD) || (instr_kind == KIND_STORE);
    op = ir[23] ? ALU_OP_ADD : ALU_OP_SUB;
    wb = !ir[24] || ir[21];

    if (m_state == M_RESET) begin
      e_addr_src = ADDR_SRC_PC;
    end else if (flush_req || m_state == M_FILL) begin
      set_fetch(ADDR_SRC_INCR);
    end else if (m_state == M_PRIME || !condition_pass || !kept) begin
      set_fetch(ADDR_SRC_PC);
      e_adv = 1'b1;
    end else if (instr_kind == KIND_DP_IMM || instr_kind == KIND_DP_REG_IMM) begin
      set_fetch(ADDR_SRC_PC);
      e_alu_op    = ir[24:21];
      e_alu_wb    = (ir[24:21] >= 4'd8 && ir[24:21] <= 4'd11) ? ALU_WB_NONE : ALU_WB_RD;
      e_set_flags = ir[20];
      e_adv       = 1'b1;
      if (instr_kind == KIND_DP_IMM) begin
        e_b_imm        = {4'd0, ir[7:0]};
        e_shift_type   = SHIFT_ROR;
        e_shift_amount = {ir[11:8], 1'b0};
      end else begin
        reg_offset();
      end
    end else if (m_step == 0) begin
      // Address step of a load or store
      set_fetch(ADDR_SRC_ALU);
      e_alu_op = op;
      if (ir[25]) begin
        reg_offset();
      end else begin
        e_b_imm = ir[11:0];
      end
      e_latch_op_b   = ir[24] ? ir[21] : 1'b1;
      e_disable_op_b = !ir[24];
    end else if (m_step == 1) begin
      e_byte_xfer      = ir[22];
      e_alu_op         = op;
      e_use_op_b_latch = wb;
      e_alu_wb         = wb ? ALU_WB_RN : ALU_WB_NONE;
      if (instr_kind == KIND_LOAD) begin
        e_mem_read = 1'b1;
      end else begin
        e_b_src     = B_SRC_RD;
        e_mem_write = 1'b1;
        e_adv       = 1'b1;
      end
    end else if (m_step == 2 && instr_kind == KIND_LOAD) begin
      e_b_src     = B_SRC_READ_DATA;
      e_alu_op    = ALU_OP_MOV;
      e_alu_wb    = ALU_WB_RD;
      e_byte_xfer = ir[22];
      e_adv       = 1'b1;
    end
  endtask

  function automatic int expected_latency(input instr_kind_t kind, input logic cond);
    if (cond && kind == KIND_LOAD) begin
      return 3;
    end
    if (cond && kind == KIND_STORE) begin
      return 2;
    end
    return 1;
  endfunction

  // ====================================================================
  // Checks and cycle driver
  // ====================================================================

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_outputs();
    check_field("addr_src", 32'(addr_src), 32'(e_addr_src));
    check_field("b_src", 32'(b_src), 32'(e_b_src));
    check_field("b_imm", 32'(b_imm), 32'(e_b_imm));
    check_field("shift_type", 32'(shift_type), 32'(e_shift_type));
    check_field("shift_amount", 32'(shift_amount), 32'(e_shift_amount));
    check_field("alu_op", 32'(alu_op), 32'(e_alu_op));
    check_field("alu_wb", 32'(alu_wb), 32'(e_alu_wb));
    check_field("set_flags", 32'(set_flags), 32'(e_set_flags));
    check_field("use_rrx", 32'(use_rrx), 32'(e_use_rrx));
    check_field("latch_op_b", 32'(latch_op_b), 32'(e_latch_op_b));
    check_field("disable_op_b", 32'(disable_op_b), 32'(e_disable_op_b));
    check_field("use_op_b_latch", 32'(use_op_b_latch), 32'(e_use_op_b_latch));
    check_field("mem_read", 32'(mem_read), 32'(e_mem_read));
    check_field("mem_write", 32'(mem_write), 32'(e_mem_write));
    check_field("byte_xfer", 32'(byte_xfer), 32'(e_byte_xfer));
    check_field("latch_ir", 32'(latch_ir), 32'(e_latch_ir));
    check_field("incr_wb", 32'(incr_wb), 32'(e_incr_wb));
    check_field("pipeline_advance", 32'(pipeline_advance), 32'(e_adv));
  endtask

  // Drive after the rising edge and compare on the falling edge
  task automatic cycle_and_check(input instr_kind_t kind, input word_t word,
                                 input logic cond, input logic flush, output logic adv);
    @(posedge clk);
    #1;
    reset          = 1'b0;
    instr_kind     = kind;
    ir             = word;
    condition_pass = cond;
    flush_req      = flush;
    @(negedge clk);
    predict();
    compare_outputs();
    adv = pipeline_advance;
    if (flush) begin
      m_state = M_PRIME;
    end else if (m_state == M_RESET) begin
      m_state = M_FILL;
    end else if (m_state == M_FILL) begin
      m_state = M_PRIME;
    end else begin
      m_state = M_RUN;
    end
    m_step = e_adv ? 0 : m_step + 1;
  endtask

  task automatic run_instr(input instr_kind_t kind, input word_t word, input logic cond,
                           input int flush_at, input int exp_latency);
    logic adv;
    int   cycles;
    adv    = 1'b0;
    cycles = 0;
    while (!adv && cycles < MAX_CYCLES) begin
      cycle_and_check(kind, word, cond, cycles == flush_at, adv);
      cycles++;
    end
    if (!adv) begin
      $display("Timeout: pipeline_advance stayed low for %0d cycles", MAX_CYCLES);
      errors++;
      hung = 1;
    end else begin
      checks++;
      assert (cycles == exp_latency) else begin
        $display("Fail at %0t: instruction took %0d cycles, expected %0d",
                 $time, cycles, exp_latency);
        errors++;
      end
    end
  endtask

  task automatic run_test(input string name, input int mode, input instr_kind_t fixed_kind,
                          input int count);
    int          first_errors;
    int          i;
    int          r;
    int          flush_at;
    int          lat;
    instr_kind_t kind;
    logic        cond;
    word_t       word;
    first_errors = errors;
    // Start-up sequence after reset leads this test
    if (mode == MODE_FLUSH) begin
      run_instr(KIND_OTHER, '0, 1'b0, -1, 3);
    end
    for (i = 0; i < count && hung == 0; i++) begin
      r        = $unsigned($random(seed)) % 10;
      word     = $random(seed);
      kind     = fixed_kind;
      cond     = 1'b1;
      flush_at = -1;
      case (mode)
        MODE_FIXED: begin
          // Force the RRX encoding now and then
          if (r < 2) word[11:5] = 7'b0000011;
        end
        MODE_FLUSH: begin
          kind     = 3'(r % 4);
          flush_at = r % 3;
        end
        MODE_SKIP: begin
          if (r < 5) begin
            kind = 3'(r % 4);
            cond = 1'b0;
          end else begin
            kind = 3'(4 + r % 4);
            cond = word[31];
          end
        end
        default: begin
          kind = 3'(r / 2);
          cond = ($unsigned($random(seed)) % 5) != 0;
          if ($unsigned($random(seed)) % 8 == 0) flush_at = $unsigned($random(seed)) % 3;
        end
      endcase
      lat = expected_latency(kind, cond);
      if (flush_at >= 0 && flush_at < lat) lat = flush_at + 2;
      run_instr(kind, word, cond, flush_at, lat);
    end
    $display("Test %s: %0d instructions, %0d errors", name, count, errors - first_errors);
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================

  initial begin
    seed           = 32'heb7e;
    clk            = 1'b0;
    reset          = 1'b1;
    flush_req      = 1'b0;
    instr_kind     = KIND_OTHER;
    condition_pass = 1'b0;
    ir             = '0;
    checks         = 0;
    errors         = 0;
    hung           = 0;
    m_state        = M_RESET;
    m_step         = 0;
    $timeformat(-9, 0, " ns", 0);

    // Third reset edge comes inside the first driven cycle
    repeat (2) @(posedge clk);

    run_test("reset_and_flush", MODE_FLUSH, KIND_OTHER, 40);
    run_test("dp_immediate", MODE_FIXED, KIND_DP_IMM, 60);
    run_test("dp_register", MODE_FIXED, KIND_DP_REG_IMM, 60);
    run_test("load", MODE_FIXED, KIND_LOAD, 60);
    run_test("store", MODE_FIXED, KIND_STORE, 60);
    run_test("skip", MODE_SKIP, KIND_OTHER, 40);
    run_test("random_mix", MODE_MIXED, KIND_OTHER, 300);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verif/arm_control_unit_assertions.sv
`timescale 1ns/1ps

module arm_control_unit_assertions (
  input logic                  clk,
  input logic                  reset,
  input logic                  mem_read,
  input logic                  mem_write,
  input logic                  pipeline_advance,
  input arm_ctrl_pkg::alu_op_t alu_op,
  input arm_ctrl_pkg::alu_wb_t alu_wb
);
  import arm_ctrl_pkg::*;

  // Single memory port, a read and a write never share a cycle
  no_read_write: assert property (@(posedge clk) disable iff (reset)
    !(mem_read && mem_write))
    else $error("mem_read and mem_write are high in the same cycle");

  // First cycle out of reset is the PC-only word
  quiet_after_reset: assert property (@(posedge clk)
    reset |=> !pipeline_advance && !mem_read && !mem_write)
    else $error("pipeline_advance or a memory strobe is high right after reset");

  // Compare group only updates flags
  compare_no_rd: assert property (@(posedge clk) disable iff (reset)
    (alu_op >= ALU_OP_TST && alu_op <= ALU_OP_CMN) |-> alu_wb != ALU_WB_RD)
    else $error("Compare operation writes back to Rd");

endmodule

bind arm_control_unit arm_control_unit_assertions arm_control_unit_assertions_inst (
  .clk              (clk),
  .reset            (reset),
  .mem_read         (mem_read),
  .mem_write        (mem_write),
  .pipeline_advance (pipeline_advance),
  .alu_op           (alu_op),
  .alu_wb           (alu_wb)
);

// File: design/arm_control_unit.sv
`timescale 1ns/1ps

module arm_control_unit (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      flush_req,
  input  arm_ctrl_pkg::instr_kind_t instr_kind,
  input  logic                      condition_pass,
  input  arm_ctrl_pkg::word_t       ir,
  output arm_ctrl_pkg::addr_src_t   addr_src,
  output arm_ctrl_pkg::b_src_t      b_src,
  output arm_ctrl_pkg::imm12_t      b_imm,
  output arm_ctrl_pkg::shift_t      shift_type,
  output arm_ctrl_pkg::shamt_t      shift_amount,
  output arm_ctrl_pkg::alu_op_t     alu_op,
  output arm_ctrl_pkg::alu_wb_t     alu_wb,
  output logic                      set_flags,
  output logic                      use_rrx,
  output logic                      latch_op_b,
  output logic                      disable_op_b,
  output logic                      use_op_b_latch,
  output logic                      mem_read,
  output logic                      mem_write,
  output logic                      byte_xfer,
  output logic                      latch_ir,
  output logic                      incr_wb,
  output logic                      pipeline_advance
);
  import arm_ctrl_pkg::*;

  step_t step;

  // Proposed words from the two step generators
  ctrl_step_if dp_step ();
  ctrl_step_if xfer_step ();

  dataproc_steps dataproc_steps_inst (
    .ir         (ir),
    .instr_kind (instr_kind),
    .step       (step),
    .out        (dp_step.producer)
  );

  transfer_steps transfer_steps_inst (
    .ir         (ir),
    .instr_kind (instr_kind),
    .step       (step),
    .out        (xfer_step.producer)
  );

  step_sequencer step_sequencer_inst (
    .clk              (clk),
    .reset            (reset),
    .flush_req        (flush_req),
    .condition_pass   (condition_pass),
    .instr_kind       (instr_kind),
    .dp               (dp_step.consumer),
    .xfer             (xfer_step.consumer),
    .step             (step),
    .addr_src         (addr_src),
    .b_src            (b_src),
    .b_imm            (b_imm),
    .shift_type       (shift_type),
    .shift_amount     (shift_amount),
    .alu_op           (alu_op),
    .alu_wb           (alu_wb),
    .set_flags        (set_flags),
    .use_rrx          (use_rrx),
    .latch_op_b       (latch_op_b),
    .disable_op_b     (disable_op_b),
    .use_op_b_latch   (use_op_b_latch),
    .mem_read         (mem_read),
    .mem_write        (mem_write),
    .byte_xfer        (byte_xfer),
    .latch_ir         (latch_ir),
    .incr_wb          (incr_wb),
    .pipeline_advance (pipeline_advance)
  );

endmodule

// File: design/step_sequencer.sv
`timescale 1ns/1ps

module step_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      flush_req,
  input  logic                      condition_pass,
  input  arm_ctrl_pkg::instr_kind_t instr_kind,
  ctrl_step_if.consumer             dp,
  ctrl_step_if.consumer             xfer,
  output arm_ctrl_pkg::step_t       step,
  output arm_ctrl_pkg::addr_src_t   addr_src,
  output arm_ctrl_pkg::b_src_t      b_src,
  output arm_ctrl_pkg::imm12_t      b_imm,
  output arm_ctrl_pkg::shift_t      shift_type,
  output arm_ctrl_pkg::shamt_t      shift_amount,
  output arm_ctrl_pkg::alu_op_t     alu_op,
  output arm_ctrl_pkg::alu_wb_t     alu_wb,
  output logic                      set_flags,
  output logic                      use_rrx,
  output logic                      latch_op_b,
  output logic                      disable_op_b,
  output logic                      use_op_b_latch,
  output logic                      mem_read,
  output logic                      mem_write,
  output logic                      byte_xfer,
  output logic                      latch_ir,
  output logic                      incr_wb,
  output logic                      pipeline_advance
);
  import arm_ctrl_pkg::*;

  typedef enum logic [1:0] {
    SEQ_RESET,
    SEQ_FILL,
    SEQ_PRIME,
    SEQ_RUN
  } seq_state_t;

  seq_state_t state;
  seq_state_t state_next;
  logic       sel_xfer;
  logic       skip;

  assign sel_xfer = (instr_kind == KIND_LOAD) || (instr_kind == KIND_STORE);

  // Failed condition or unsupported kind just fetches the next one
  assign skip = !condition_pass || !(sel_xfer || instr_kind == KIND_DP_IMM ||
                                     instr_kind == KIND_DP_REG_IMM);

  always_comb begin
    case (state)
      SEQ_RESET: state_next = SEQ_FILL;
      SEQ_FILL:  state_next = SEQ_PRIME;
      default:   state_next = SEQ_RUN;
    endcase
    if (flush_req) state_next = SEQ_PRIME;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= SEQ_RESET;
      step  <= '0;
    end else begin
      state <= state_next;
      step  <= pipeline_advance ? 8'd0 : step + 8'd1;
    end
  end

  // ======================================================================
  // Control word selection
  // ======================================================================
  always_comb begin
    addr_src         = ADDR_SRC_PC;
    b_src            = B_SRC_IMM;
    b_imm            = '0;
    shift_type       = SHIFT_LSL;
    shift_amount     = '0;
    alu_op           = '0;
    alu_wb           = ALU_WB_NONE;
    set_flags        = 1'b0;
    use_rrx          = 1'b0;
    latch_op_b       = 1'b0;
    disable_op_b     = 1'b0;
    use_op_b_latch   = 1'b0;
    mem_read         = 1'b0;
    mem_write        = 1'b0;
    byte_xfer        = 1'b0;
    latch_ir         = 1'b0;
    incr_wb          = 1'b0;
    pipeline_advance = 1'b0;

    if (state == SEQ_RESET) begin
      // Only PC drives the address bus on the first cycle
      addr_src = ADDR_SRC_PC;
    end else if (flush_req || state != SEQ_RUN || skip) begin
      mem_read = 1'b1;
      latch_ir = 1'b1;
      incr_wb  = 1'b1;
      if (flush_req || state == SEQ_FILL) begin
        addr_src = ADDR_SRC_INCR;
      end else begin
        pipeline_advance = 1'b1;
      end
    end else begin
      addr_src         = sel_xfer ? xfer.addr_src       : dp.addr_src;
      b_src            = sel_xfer ? xfer.b_src          : dp.b_src;
      b_imm            = sel_xfer ? xfer.b_imm          : dp.b_imm;
      shift_type       = sel_xfer ? xfer.shift_type     : dp.shift_type;
      shift_amount     = sel_xfer ? xfer.shift_amount   : dp.shift_amount;
      alu_op           = sel_xfer ? xfer.alu_op         : dp.alu_op;
      alu_wb           = sel_xfer ? xfer.alu_wb         : dp.alu_wb;
      set_flags        = sel_xfer ? xfer.set_flags      : dp.set_flags;
      use_rrx          = sel_xfer ? xfer.use_rrx        : dp.use_rrx;
      latch_op_b       = sel_xfer ? xfer.latch_op_b     : dp.latch_op_b;
      disable_op_b     = sel_xfer ? xfer.disable_op_b   : dp.disable_op_b;
      use_op_b_latch   = sel_xfer ? xfer.use_op_b_latch : dp.use_op_b_latch;
      mem_read         = sel_xfer ? xfer.mem_read       : dp.mem_read;
      mem_write        = sel_xfer ? xfer.mem_write      : dp.mem_write;
      byte_xfer        = sel_xfer ? xfer.byte_xfer      : dp.byte_xfer;
      latch_ir         = sel_xfer ? xfer.latch_ir       : dp.latch_ir;
      incr_wb          = sel_xfer ? xfer.incr_wb        : dp.incr_wb;
      pipeline_advance = sel_xfer ? xfer.last           : dp.last;
    end
  end

endmodule

// File: design/transfer_steps.sv
`timescale 1ns/1ps

module transfer_steps (
  input  arm_ctrl_pkg::word_t       ir,
  input  arm_ctrl_pkg::instr_kind_t instr_kind,
  input  arm_ctrl_pkg::step_t       step,
  ctrl_step_if.producer             out
);
  import arm_ctrl_pkg::*;

  logic    is_load;
  logic    is_store;
  logic    wb_needed;
  alu_op_t offset_op;
  shift_t  reg_shift_type;
  shamt_t  reg_shift_amount;

  assign is_load  = (instr_kind == KIND_LOAD);
  assign is_store = (instr_kind == KIND_STORE);

  // Base register is updated when post-indexed or W is set
  assign wb_needed = !ir[P_BIT] || ir[W_BIT];

  // U picks add or subtract of the offset
  assign offset_op = ir[U_BIT] ? ALU_OP_ADD : ALU_OP_SUB;

  assign reg_shift_type   = ir[SHTYPE_LSB +: 2];
  assign reg_shift_amount = ir[SHAMT_LSB +: 5];

  always_comb begin
    out.addr_src       = ADDR_SRC_PC;
    out.b_src          = B_SRC_IMM;
    out.b_imm          = '0;
    out.shift_type     = SHIFT_LSL;
    out.shift_amount   = '0;
    out.alu_op         = '0;
    out.alu_wb         = ALU_WB_NONE;
    out.set_flags      = 1'b0;
    out.use_rrx        = 1'b0;
    out.latch_op_b     = 1'b0;
    out.disable_op_b   = 1'b0;
    out.use_op_b_latch = 1'b0;
    out.mem_read       = 1'b0;
    out.mem_write      = 1'b0;
    out.byte_xfer      = 1'b0;
    out.latch_ir       = 1'b0;
    out.incr_wb        = 1'b0;
    out.last           = 1'b0;

    // ====================================================================
    // Step 0: address calculation, overlapped with the next fetch
    // ====================================================================
    if ((is_load || is_store) && step == 8'd0) begin
      out.mem_read = 1'b1;
      out.latch_ir = 1'b1;
      out.incr_wb  = 1'b1;
      out.addr_src = ADDR_SRC_ALU;
      out.alu_op   = offset_op;

      if (!ir[I_BIT]) begin
        out.b_src = B_SRC_IMM;
        out.b_imm = ir[11:0];
      end else begin
        out.b_src        = B_SRC_RM;
        out.shift_type   = reg_shift_type;
        out.shift_amount = reg_shift_amount;
        out.use_rrx      = (reg_shift_type == SHIFT_ROR) && (reg_shift_amount == 5'd0);
      end

      if (ir[P_BIT]) begin
        out.latch_op_b = ir[W_BIT];
      end else begin
        // Post-index puts the bare base on the bus and keeps the offset
        out.disable_op_b = 1'b1;
        out.latch_op_b   = 1'b1;
      end

    // ====================================================================
    // Later steps: memory access and base write-back
    // ====================================================================
    end else if (is_load && step == 8'd1) begin
      out.mem_read       = 1'b1;
      out.byte_xfer      = ir[B_BIT];
      out.alu_op         = offset_op;
      out.use_op_b_latch = wb_needed;
      out.alu_wb         = wb_needed ? ALU_WB_RN : ALU_WB_NONE;
    end else if (is_load && step == 8'd2) begin
      // Read data passes through the ALU into Rd
      out.b_src     = B_SRC_READ_DATA;
      out.alu_op    = ALU_OP_MOV;
      out.alu_wb    = ALU_WB_RD;
      out.byte_xfer = ir[B_BIT];
      out.last      = 1'b1;
    end else if (is_store && step == 8'd1) begin
      out.b_src          = B_SRC_RD;
      out.mem_write      = 1'b1;
      out.byte_xfer      = ir[B_BIT];
      out.alu_op         = offset_op;
      out.use_op_b_latch = wb_needed;
      out.alu_wb         = wb_needed ? ALU_WB_RN : ALU_WB_NONE;
      out.last           = 1'b1;
    end
  end

endmodule

// File: design/dataproc_steps.sv
`timescale 1ns/1ps

module dataproc_steps (
  input  arm_ctrl_pkg::word_t       ir,
  input  arm_ctrl_pkg::instr_kind_t instr_kind,
  input  arm_ctrl_pkg::step_t       step,
  ctrl_step_if.producer             out
);
  import arm_ctrl_pkg::*;

  alu_op_t opcode;
  shift_t  reg_shift_type;
  shamt_t  reg_shift_amount;

  assign opcode           = ir[OPCODE_LSB +: 4];
  assign reg_shift_type   = ir[SHTYPE_LSB +: 2];
  assign reg_shift_amount = ir[SHAMT_LSB +: 5];

  always_comb begin
    out.addr_src       = ADDR_SRC_PC;
    out.b_src          = B_SRC_IMM;
    out.b_imm          = '0;
    out.shift_type     = SHIFT_LSL;
    out.shift_amount   = '0;
    out.alu_op         = '0;
    out.alu_wb         = ALU_WB_NONE;
    out.set_flags      = 1'b0;
    out.use_rrx        = 1'b0;
    out.latch_op_b     = 1'b0;
    out.disable_op_b   = 1'b0;
    out.use_op_b_latch = 1'b0;
    out.mem_read       = 1'b0;
    out.mem_write      = 1'b0;
    out.byte_xfer      = 1'b0;
    out.latch_ir       = 1'b0;
    out.incr_wb        = 1'b0;
    out.last           = 1'b0;

    if ((instr_kind == KIND_DP_IMM || instr_kind == KIND_DP_REG_IMM) && step == 8'd0) begin
      if (instr_kind == KIND_DP_IMM) begin
        // imm8 rotated right by twice the 4-bit rotate field
        out.b_src        = B_SRC_IMM;
        out.b_imm        = {4'd0, ir[7:0]};
        out.shift_type   = SHIFT_ROR;
        out.shift_amount = {ir[ROT_LSB +: 4], 1'b0};
      end else begin
        out.b_src        = B_SRC_RM;
        out.shift_type   = reg_shift_type;
        out.shift_amount = reg_shift_amount;
        // ROR #0 encodes RRX
        out.use_rrx      = (reg_shift_type == SHIFT_ROR) && (reg_shift_amount == 5'd0);
      end

      out.alu_op    = opcode;
      out.alu_wb    = alu_wb_for_op(opcode);
      out.set_flags = ir[S_BIT];

      // Single cycle, fetch the next instruction alongside
      out.mem_read  = 1'b1;
      out.latch_ir  = 1'b1;
      out.incr_wb   = 1'b1;
      out.last      = 1'b1;
    end
  end

endmodule

// File: design/ctrl_step_if.sv
`timescale 1ns/1ps

interface ctrl_step_if;
  import arm_ctrl_pkg::*;

  addr_src_t addr_src;
  b_src_t    b_src;
  imm12_t    b_imm;
  shift_t    shift_type;
  shamt_t    shift_amount;
  alu_op_t   alu_op;
  alu_wb_t   alu_wb;
  logic      set_flags;
  logic      use_rrx;

  // Operand B latch used by indexed transfers
  logic      latch_op_b;
  logic      disable_op_b;
  logic      use_op_b_latch;

  logic      mem_read;
  logic      mem_write;
  logic      byte_xfer;
  logic      latch_ir;
  logic      incr_wb;

  // High in the step that finishes the instruction
  logic      last;

  modport producer (
    output addr_src, b_src, b_imm, shift_type, shift_amount,
    output alu_op, alu_wb, set_flags, use_rrx,
    output latch_op_b, disable_op_b, use_op_b_latch,
    output mem_read, mem_write, byte_xfer, latch_ir, incr_wb,
    output last
  );

  modport consumer (
    input addr_src, b_src, b_imm, shift_type, shift_amount,
    input alu_op, alu_wb, set_flags, use_rrx,
    input latch_op_b, disable_op_b, use_op_b_latch,
    input mem_read, mem_write, byte_xfer, latch_ir, incr_wb,
    input last
  );

endinterface

// File: design/arm_ctrl_pkg.sv
package arm_ctrl_pkg;

  // ======================================================================
  // Types for fields with a fixed meaning
  // ======================================================================

  typedef logic [31:0] word_t;
  typedef logic [2:0]  instr_kind_t;
  typedef logic [7:0]  step_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [1:0]  alu_wb_t;
  typedef logic [1:0]  addr_src_t;
  typedef logic [1:0]  b_src_t;
  typedef logic [1:0]  shift_t;
  typedef logic [4:0]  shamt_t;
  typedef logic [11:0] imm12_t;

  // Instruction kinds from the decoder
  localparam instr_kind_t KIND_DP_IMM     = 3'd0;
  localparam instr_kind_t KIND_DP_REG_IMM = 3'd1;
  localparam instr_kind_t KIND_LOAD       = 3'd2;
  localparam instr_kind_t KIND_STORE      = 3'd3;
  localparam instr_kind_t KIND_OTHER      = 3'd4;

  // ALU operations, same numbering as the ARM opcode field
  localparam alu_op_t ALU_OP_SUB = 4'd2;
  localparam alu_op_t ALU_OP_ADD = 4'd4;
  localparam alu_op_t ALU_OP_TST = 4'd8;
  localparam alu_op_t ALU_OP_TEQ = 4'd9;
  localparam alu_op_t ALU_OP_CMP = 4'd10;
  localparam alu_op_t ALU_OP_CMN = 4'd11;
  localparam alu_op_t ALU_OP_MOV = 4'd13;

  localparam alu_wb_t ALU_WB_NONE = 2'd0;
  localparam alu_wb_t ALU_WB_RD   = 2'd1;
  localparam alu_wb_t ALU_WB_RN   = 2'd2;

  localparam addr_src_t ADDR_SRC_PC   = 2'd0;
  localparam addr_src_t ADDR_SRC_INCR = 2'd1;
  localparam addr_src_t ADDR_SRC_ALU  = 2'd2;

  localparam b_src_t B_SRC_IMM       = 2'd0;
  localparam b_src_t B_SRC_RM        = 2'd1;
  localparam b_src_t B_SRC_RD        = 2'd2;
  localparam b_src_t B_SRC_READ_DATA = 2'd3;

  localparam shift_t SHIFT_LSL = 2'd0;
  localparam shift_t SHIFT_LSR = 2'd1;
  localparam shift_t SHIFT_ASR = 2'd2;
  localparam shift_t SHIFT_ROR = 2'd3;

  // ======================================================================
  // Bit positions inside ir
  // ======================================================================

  localparam int OPCODE_LSB = 21;
  localparam int S_BIT      = 20;
  localparam int ROT_LSB    = 8;
  localparam int SHTYPE_LSB = 5;
  localparam int SHAMT_LSB  = 7;
  localparam int P_BIT      = 24;
  localparam int U_BIT      = 23;
  localparam int B_BIT      = 22;
  localparam int W_BIT      = 21;
  localparam int I_BIT      = 25;

  // Compare ops only update flags, everything else writes Rd
  function automatic alu_wb_t alu_wb_for_op(alu_op_t op);
    case (op)
      ALU_OP_TST, ALU_OP_TEQ, ALU_OP_CMP, ALU_OP_CMN: alu_wb_for_op = ALU_WB_NONE;
      default: alu_wb_for_op = ALU_WB_RD;
    endcase
  endfunction

endpackage
